/* controlUnit.f */
src/cpuPkg.sv
src/instructionDecoder.sv
src/stepSequencer.sv
src/controlWordRom.sv
src/controlUnit.sv
sim/controlUnit_properties.sv
sim/controlUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f controlUnit.f \
	--top-module controlUnitTb -o controlUnitSim \
	&& ./obj_dir/controlUnitSim 2>&1 | tee sim.log \
	|| { echo "Simulation build or run failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* sim/controlUnitTb.sv */
`timescale 1ns/100ps

module controlUnitTb;

	logic clk;
	logic reset;
	cpuPkg::instruction_t getInst;
	cpuPkg::controlWord_t controlWord;
	int errorCount;
	int checkCount;
	int seed;

	controlUnit DUT
	(
		.clk(clk),
		.reset(reset),
		.getInst(getInst),
		.controlWord(controlWord)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic checkValue
	(
		input string testName,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("** Error %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	// Strobe bits run incPC rPC rMAR wMAR rMem wMem rMDR wMDRmem rIR wIR rAC wAC
	function automatic cpuPkg::controlWord_t packWord
	(
		input logic [11:0] strobes,
		input cpuPkg::aluFunc_t func,
		input logic en
	);
		packWord = cpuPkg::controlWord_t'({strobes, func, en});
	endfunction

	function automatic cpuPkg::microOp_t refKind(input cpuPkg::instruction_t inst);
		refKind = cpuPkg::uopIllegal;
		if (inst.mode == 2'd1)	// Direct mode only
		begin
			case (inst.opcode)
				3'd0: refKind = cpuPkg::uopAdd;
				3'd1: refKind = cpuPkg::uopLoad;
				3'd2: refKind = cpuPkg::uopStore;
				default: refKind = cpuPkg::uopIllegal;
			endcase
		end
	endfunction

	function automatic int refLength(input cpuPkg::microOp_t kind);
		case (kind)
			cpuPkg::uopStore: refLength = 12;
			cpuPkg::uopIllegal: refLength = 8;
			default: refLength = 14;
		endcase
	endfunction

	// Expected word for a step of the given instruction kind
	function automatic cpuPkg::controlWord_t refWord
	(
		input int step,
		input cpuPkg::microOp_t kind
	);
		logic add;
		cpuPkg::aluFunc_t readFunc;
		cpuPkg::aluFunc_t tailFunc;
		add = (kind == cpuPkg::uopAdd);
		readFunc = add ? cpuPkg::aluAdd : cpuPkg::aluPassA;
		tailFunc = add ? cpuPkg::aluAdd : cpuPkg::aluPassB;
		refWord = packWord('0, cpuPkg::aluPassA, 1'b0);	// Illegal step 7 and unlisted steps
		case (step)
			0: refWord = packWord(12'b01_00_00_00_00_00, cpuPkg::aluPassB, 1'b1);
			1: refWord = packWord(12'b00_01_00_00_00_00, cpuPkg::aluPassB, 1'b1);
			2: refWord = packWord(12'b00_10_10_00_00_00, cpuPkg::aluPassA, 1'b0);
			3: refWord = packWord(12'b00_10_10_01_00_00, cpuPkg::aluPassB, 1'b0);
			4: refWord = packWord(12'b00_00_00_01_00_00, cpuPkg::aluPassB, 1'b1);
			5: refWord = packWord(12'b10_00_00_10_01_00, cpuPkg::aluPassB, 1'b1);
			6: refWord = packWord(12'b00_00_00_00_01_00, cpuPkg::aluPassA, 1'b0);
			default: ;
		endcase
		if (kind == cpuPkg::uopStore)
		begin
			case (step)
				7: refWord = packWord(12'b00_00_00_00_10_00, cpuPkg::aluPassA, 1'b1);
				8: refWord = packWord(12'b00_01_00_00_00_00, cpuPkg::aluPassA, 1'b0);
				9: refWord = packWord(12'b00_00_00_00_00_10, cpuPkg::aluPassA, 1'b1);
				10, 11: refWord = packWord(12'b00_10_01_00_10_00, cpuPkg::aluPassB, 1'b0);
				default: ;
			endcase
		end
		else if (kind != cpuPkg::uopIllegal)
		begin
			case (step)
				7: refWord = packWord(12'b00_00_00_00_10_00, cpuPkg::aluPassA, 1'b1);
				8: refWord = packWord(12'b00_01_00_00_00_00, cpuPkg::aluPassA, 1'b0);
				9, 10: refWord = packWord(12'b00_10_10_00_00_00, readFunc, 1'b0);
				11: refWord = packWord(12'b00_00_00_01_00_00, tailFunc, 1'b1);
				12: refWord = packWord({10'b00_00_00_10_00, add, 1'b0}, tailFunc, 1'b1);
				13: refWord = packWord(12'b00_00_00_00_00_01, tailFunc, 1'b0);
				default: ;
			endcase
		end
	endfunction

	function automatic cpuPkg::instruction_t makeInst
	(
		input logic [2:0] op,
		input logic [1:0] mode
	);
		logic [12:0] address;
		address = 13'($random(seed));
		makeInst = cpuPkg::instruction_t'({op, mode, address});
	endfunction

	// Called just after a falling edge, returns on the next step-0 word
	task automatic runInstruction
	(
		input string name,
		input cpuPkg::instruction_t inst,
		output int cycles
	);
		cpuPkg::microOp_t kind;
		cpuPkg::controlWord_t fetchWord;
		int waited;
		int count;
		kind = refKind(inst);
		fetchWord = refWord(0, kind);
		waited = 0;
		while (controlWord != fetchWord && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (controlWord != fetchWord)
		begin
			errorCount++;
			$display("%s never saw the step-0 fetch word", name);
		end
		@(posedge clk);
		getInst <= inst;	// Held until the next instruction
		count = 1;
		@(negedge clk);
		while (controlWord != fetchWord && count < 16)
		begin
			checkValue($sformatf("%s step %0d", name, count), {16'h0, refWord(count, kind)},
				{16'h0, controlWord});
			count++;
			@(negedge clk);
		end
		checkValue({name, " length"}, refLength(kind), count);
		cycles = waited + count;
	endtask

	task automatic resetTest;
		@(negedge clk);
		checkValue("reset clear", 32'h0, {16'h0, controlWord});
		@(negedge clk);
		checkValue("reset first word", {16'h0, refWord(0, cpuPkg::uopIllegal)},
			{16'h0, controlWord});
	endtask

	task automatic addTest;
		int cycles;
		runInstruction("add", makeInst(3'd0, 2'd1), cycles);
	endtask

	task automatic loadTest;
		int cycles;
		runInstruction("load", makeInst(3'd1, 2'd1), cycles);
	endtask

	task automatic storeTest;
		int cycles;
		runInstruction("store", makeInst(3'd2, 2'd1), cycles);
	endtask

	task automatic illegalTest;
		int cycles;
		runInstruction("illegal opcode", makeInst(3'd5, 2'd1), cycles);
		runInstruction("illegal mode", makeInst(3'd0, 2'd0), cycles);
	endtask

	task automatic backToBackTest;
		cpuPkg::instruction_t instList [4];
		int cycles;
		int total;
		instList[0] = makeInst(3'd0, 2'd1);
		instList[1] = makeInst(3'd2, 2'd1);
		instList[2] = makeInst(3'd1, 2'd1);
		instList[3] = makeInst(3'd6, 2'd1);
		total = 0;
		foreach (instList[i])
		begin
			runInstruction($sformatf("sequence %0d", i), instList[i], cycles);
			total += cycles;
		end
		checkValue("sequence total", 14 + 12 + 14 + 8, total);	// No gaps between instructions
	endtask

	initial
	begin
		reset = 1'b1;
		getInst = '0;
		errorCount = 0;
		checkCount = 0;
		seed = 32'he14d;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		resetTest();
		addTest();
		loadTest();
		storeTest();
		illegalTest();
		backToBackTest();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial
	begin
		int budget;
		budget = 4 + 2 + 14 + 14 + 12 + 8 + 8 + 48 + 50;	// Test cycles plus margin
		#(budget * 100);
		$display("Timeout after %0d cycles, the tests did not finish", budget);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim/controlUnit_properties.sv */
`timescale 1ns/100ps

module controlUnitProperties
(
	input logic clk,
	input logic reset,
	input cpuPkg::controlWord_t controlWord,
	input logic [cpuPkg::stepWidth-1:0] step
);

	memReadWrite: assert property (@(posedge clk) disable iff (reset)
		!(controlWord.rMem && controlWord.wMem))
		else $error("Memory read and write strobes high together");

	// IR and MDR share the bus
	busDrivers: assert property (@(posedge clk) disable iff (reset)
		!(controlWord.rIR && controlWord.rMDR))
		else $error("IR and MDR drive the bus together");

	stepRange: assert property (@(posedge clk) disable iff (reset)
		step <= cpuPkg::stepLastAddLoad)
		else $error("Step counter went past the last ADD step");

	resetWord: assert property (@(posedge clk) $past(reset) |-> controlWord == '0)
		else $error("Control word not cleared after reset");

endmodule

bind controlUnit controlUnitProperties props
(
	.clk(clk),
	.reset(reset),
	.controlWord(controlWord),
	.step(step)
);

/* src/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit
(
	input logic clk,
	input logic reset,
	input cpuPkg::instruction_t getInst,
	output cpuPkg::controlWord_t controlWord
);

	logic [cpuPkg::stepWidth-1:0] step;
	cpuPkg::microOp_t microOp;

	// Registered word feeds back so wIR loads the IR
	instructionDecoder decoder
	(
		.clk(clk),
		.reset(reset),
		.getInst(getInst),
		.controlWord(controlWord),
		.microOp(microOp)
	);

	stepSequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.microOp(microOp),
		.step(step)
	);

	controlWordRom rom
	(
		.clk(clk),
		.reset(reset),
		.step(step),
		.microOp(microOp),
		.controlWord(controlWord)
	);

endmodule

/* src/controlWordRom.sv */
`timescale 1ns/100ps

module controlWordRom
(
	input logic clk,
	input logic reset,
	input logic [cpuPkg::stepWidth-1:0] step,
	input cpuPkg::microOp_t microOp,
	output cpuPkg::controlWord_t controlWord
);

	cpuPkg::controlWord_t nextWord;
	logic isAdd;

	assign isAdd = (microOp == cpuPkg::uopAdd);	// ADD and LOAD differ mostly in ALU func

	always_comb
	begin
		nextWord = '0;
		nextWord.aluFunc = cpuPkg::aluPassA;
		if (step <= cpuPkg::stepLastFetch)
		begin
			case (step)
				4'd0:
				begin
					nextWord.rPC = 1'b1;	// PC onto B bus
					nextWord.aluFunc = cpuPkg::aluPassB;
					nextWord.aluEnable = 1'b1;
				end
				4'd1:
				begin
					nextWord.wMAR = 1'b1;	// MAR <- PC
					nextWord.aluFunc = cpuPkg::aluPassB;
					nextWord.aluEnable = 1'b1;
				end
				4'd2:
				begin
					nextWord.rMAR = 1'b1;	// Memory read starts
					nextWord.rMem = 1'b1;
				end
				4'd3:
				begin
					nextWord.rMAR = 1'b1;
					nextWord.rMem = 1'b1;
					nextWord.wMDRmem = 1'b1;
					nextWord.aluFunc = cpuPkg::aluPassB;
				end
				4'd4:
				begin
					nextWord.wMDRmem = 1'b1;	// MDR <- Mem[MAR]
					nextWord.aluFunc = cpuPkg::aluPassB;
					nextWord.aluEnable = 1'b1;
				end
				4'd5:
				begin
					nextWord.incPC = 1'b1;
					nextWord.rMDR = 1'b1;	// IR <- MDR
					nextWord.wIR = 1'b1;
					nextWord.aluFunc = cpuPkg::aluPassB;
					nextWord.aluEnable = 1'b1;
				end
				default:
				begin
					nextWord.wIR = 1'b1;	// Second IR load, step 6
				end
			endcase
		end
		else if (microOp == cpuPkg::uopStore)
		begin
			case (step)
				4'd7:
				begin
					nextWord.rIR = 1'b1;	// Address field onto A bus
					nextWord.aluEnable = 1'b1;
				end
				4'd8:
				begin
					nextWord.wMAR = 1'b1;
				end
				4'd9:
				begin
					nextWord.rAC = 1'b1;
					nextWord.aluEnable = 1'b1;
				end
				4'd10, 4'd11:
				begin
					nextWord.rMAR = 1'b1;	// Mem[MAR] <- AC
					nextWord.wMem = 1'b1;
					nextWord.rIR = 1'b1;
					nextWord.aluFunc = cpuPkg::aluPassB;
				end
				default:
				begin
					nextWord.aluFunc = cpuPkg::aluPassA;
				end
			endcase
		end
		else if (microOp != cpuPkg::uopIllegal)
		begin
			case (step)
				4'd7:
				begin
					nextWord.rIR = 1'b1;
					nextWord.aluEnable = 1'b1;
				end
				4'd8:
				begin
					nextWord.wMAR = 1'b1;	// MAR <- IR address
				end
				4'd9, 4'd10:
				begin
					nextWord.rMAR = 1'b1;	// Operand read
					nextWord.rMem = 1'b1;
					nextWord.aluFunc = isAdd ? cpuPkg::aluAdd : cpuPkg::aluPassA;
				end
				4'd11:
				begin
					nextWord.wMDRmem = 1'b1;
					nextWord.aluFunc = isAdd ? cpuPkg::aluAdd : cpuPkg::aluPassB;
					nextWord.aluEnable = 1'b1;
				end
				4'd12:
				begin
					nextWord.rMDR = 1'b1;
					nextWord.rAC = isAdd;	// Accumulator only feeds the adder
					nextWord.aluFunc = isAdd ? cpuPkg::aluAdd : cpuPkg::aluPassB;
					nextWord.aluEnable = 1'b1;
				end
				4'd13:
				begin
					nextWord.wAC = 1'b1;	// Result into AC
					nextWord.aluFunc = isAdd ? cpuPkg::aluAdd : cpuPkg::aluPassB;
				end
				default:
				begin
					nextWord.aluFunc = cpuPkg::aluPassA;
				end
			endcase
		end
	end

	// Output lags the counter by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			controlWord <= '0;
		end
		else
		begin
			controlWord <= nextWord;
		end
	end

endmodule

/* src/cpuPkg.sv */
package cpuPkg;

	localparam int instWidth = 18;
	localparam int opWidth = 3;
	localparam int modeWidth = 2;
	localparam int addrWidth = instWidth - opWidth - modeWidth;	// 13-bit address field
	localparam int stepWidth = 4;

	// Opcodes that the execute phase knows about
	typedef enum logic [opWidth-1:0]
	{
		opAdd = 3'd0,	// AC <- AC + Mem[addr]
		opLoad = 3'd1,	// AC <- Mem[addr]
		opStore = 3'd2	// Mem[addr] <- AC
	} opcode_t;

	typedef enum logic [modeWidth-1:0]
	{
		modeDirect = 2'd1	// Address taken from the instruction
	} addrMode_t;

	typedef struct packed
	{
		opcode_t opcode;
		addrMode_t mode;
		logic [addrWidth-1:0] address;
	} instruction_t;

	typedef enum logic [2:0]
	{
		aluPassA = 3'd0,	// A bus straight through
		aluPassB = 3'd1,	// B bus straight through
		aluAdd = 3'd3	// A + B
	} aluFunc_t;

	// Result of decoding the held instruction
	typedef enum logic [1:0]
	{
		uopAdd,
		uopLoad,
		uopStore,
		uopIllegal
	} microOp_t;

	// Datapath strobes, r = drive onto a bus, w = load from a bus
	typedef struct packed
	{
		logic incPC;
		logic rPC;
		logic rMAR;
		logic wMAR;
		logic rMem;
		logic wMem;
		logic rMDR;
		logic wMDRmem;	// MDR loads from memory
		logic rIR;
		logic wIR;
		logic rAC;
		logic wAC;
		aluFunc_t aluFunc;
		logic aluEnable;
	} controlWord_t;

	// Sequence boundaries
	localparam logic [stepWidth-1:0] stepLastFetch = 4'd6;
	localparam logic [stepWidth-1:0] stepFirstExecute = 4'd7;	// Also the end of an illegal op
	localparam logic [stepWidth-1:0] stepLastStore = 4'd11;
	localparam logic [stepWidth-1:0] stepLastAddLoad = 4'd13;

endpackage

/* src/instructionDecoder.sv */
`timescale 1ns/100ps

module instructionDecoder
(
	input logic clk,
	input logic reset,
	input cpuPkg::instruction_t getInst,
	input cpuPkg::controlWord_t controlWord,
	output cpuPkg::microOp_t microOp
);

	cpuPkg::instruction_t heldInst;	// Instruction register

	// Loaded from the memory word while the registered word has wIR set
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			heldInst <= '0;	// Decodes as illegal
		end
		else if (controlWord.wIR)
		begin
			heldInst <= getInst;
		end
	end

	// Only direct mode is implemented, every other mode is illegal
	always_comb
	begin
		microOp = cpuPkg::uopIllegal;
		if (heldInst.mode == cpuPkg::modeDirect)
		begin
			case (heldInst.opcode)
				cpuPkg::opAdd:
				begin
					microOp = cpuPkg::uopAdd;
				end
				cpuPkg::opLoad:
				begin
					microOp = cpuPkg::uopLoad;
				end
				cpuPkg::opStore:
				begin
					microOp = cpuPkg::uopStore;
				end
				default:
				begin
					microOp = cpuPkg::uopIllegal;	// Unknown opcode
				end
			endcase
		end
	end

endmodule

/* src/stepSequencer.sv */
`timescale 1ns/100ps

module stepSequencer
(
	input logic clk,
	input logic reset,
	input cpuPkg::microOp_t microOp,
	output logic [cpuPkg::stepWidth-1:0] step
);

	logic [cpuPkg::stepWidth-1:0] lastStep;
	logic atEnd;

	// Final step of each instruction kind
	always_comb
	begin
		case (microOp)
			cpuPkg::uopAdd:
			begin
				lastStep = cpuPkg::stepLastAddLoad;
			end
			cpuPkg::uopLoad:
			begin
				lastStep = cpuPkg::stepLastAddLoad;
			end
			cpuPkg::uopStore:
			begin
				lastStep = cpuPkg::stepLastStore;
			end
			default:
			begin
				lastStep = cpuPkg::stepFirstExecute;	// One idle execute step
			end
		endcase
	end

	// Fetch always completes since every last step lies in execute
	assign atEnd = (step == lastStep);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			step <= '0;
		end
		else if (atEnd)
		begin
			step <= '0;	// Straight back to fetch
		end
		else
		begin
			step <= step + 1'b1;
		end
	end

endmodule
